// ==== hw/sram_macros.svh ====
`ifndef SRAM_MACROS_SVH
`define SRAM_MACROS_SVH

// client side word address width
`define SRAM_WORD_ADDR_BITS 18

// pin address is one bit wider, the top bit is always driven low
`define SRAM_PIN_ADDR_BITS 19

`define SRAM_DATA_BITS 64

// active low byte write enables
`define SRAM_WE_BITS 8

// active low output enables
`define SRAM_OE_BITS 2

// words held by the behavioral model, indexed by the low address bits
`define SRAM_MODEL_DEPTH_LOG2 10

`endif

// ==== hw/sram_bus_pkg.sv ====
`default_nettype none

`include "sram_macros.svh"

package sram_bus_pkg;

    // one word on the sram data bus
    typedef logic [`SRAM_DATA_BITS-1:0] data_word_t;

    typedef logic [`SRAM_PIN_ADDR_BITS-1:0] pin_addr_t;

    // all bits move together since byte masking is not used
    typedef logic [`SRAM_WE_BITS-1:0] we_mask_t;

    typedef logic [`SRAM_OE_BITS-1:0] oe_pair_t;

endpackage

`default_nettype wire

// ==== hw/sram_ctrl_pkg.sv ====
`default_nettype none

`include "sram_macros.svh"

package sram_ctrl_pkg;

    typedef logic [`SRAM_WORD_ADDR_BITS-1:0] word_addr_t;

    typedef enum logic [2:0] {
        idle            = 3'd0,
        burst_open      = 3'd1,
        burst_wait_data = 3'd2,
        burst_data_held = 3'd3,
        burst_close     = 3'd4,
        read_capture    = 3'd5
    } ctrl_state_t;

    // debug code seen on statepeek, zero only while in reset
    typedef logic [2:0] state_peek_t;

    localparam state_peek_t peek_idle            = 3'd1;
    localparam state_peek_t peek_burst_open      = 3'd2;
    localparam state_peek_t peek_burst_wait_data = 3'd3;
    localparam state_peek_t peek_burst_data_held = 3'd4;
    localparam state_peek_t peek_burst_close     = 3'd5;
    localparam state_peek_t peek_read_capture    = 3'd6;

endpackage

`default_nettype wire

// ==== hw/sram_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_controller (
    input  wire logic                      clk,
    input  wire logic                      globalreset,
    output logic                           want_addr,
    input  wire logic                      addr_ready,
    input  wire sram_ctrl_pkg::word_addr_t addrin,
    output logic                           want_data,
    input  wire logic                      data_ready,
    input  wire sram_bus_pkg::data_word_t  datain,
    input  wire sram_ctrl_pkg::word_addr_t addr,
    input  wire logic                      addrvalid,
    output sram_bus_pkg::data_word_t       data,
    output logic                           datavalid,
    output sram_ctrl_pkg::state_peek_t     statepeek,
    input  wire sram_bus_pkg::data_word_t  sram_data_in,
    output sram_bus_pkg::data_word_t       sram_data_out,
    output sram_bus_pkg::pin_addr_t        sram_addr,
    output sram_bus_pkg::we_mask_t         sram_we,
    output sram_bus_pkg::oe_pair_t         sram_oe,
    output logic                           sram_adsp
);

    sram_ctrl_pkg::ctrl_state_t state;
    sram_ctrl_pkg::ctrl_state_t state_next;
    sram_ctrl_pkg::word_addr_t  waddr;      // burst write pointer
    sram_ctrl_pkg::word_addr_t  waddr_next;
    sram_bus_pkg::data_word_t   data_next;
    logic                       datavalid_next;
    sram_ctrl_pkg::state_peek_t peek_next;

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            state     <= sram_ctrl_pkg::idle;
            waddr     <= '0;
            data      <= '0;
            datavalid <= 1'b0;
            statepeek <= '0;
        end
        else
        begin
            state     <= state_next;
            waddr     <= waddr_next;
            data      <= data_next;
            datavalid <= datavalid_next;
            statepeek <= peek_next;  // code of the state this cycle was spent in
        end
    end

    always_comb
    begin
        state_next     = state;
        waddr_next     = waddr;
        data_next      = data;
        datavalid_next = datavalid;
        peek_next      = statepeek;
        want_addr      = 1'b0;
        want_data      = 1'b0;
        sram_addr      = '0;
        sram_data_out  = '0;
        sram_we        = '1;
        sram_oe        = '1;
        sram_adsp      = 1'b1;

        case (state)
            sram_ctrl_pkg::idle:
            begin
                want_addr = 1'b1;
                peek_next = sram_ctrl_pkg::peek_idle;
                if (!addrvalid)
                begin
                    datavalid_next = 1'b0;  // the client has taken the last read
                end
                if (addr_ready)
                begin
                    waddr_next = addrin;
                    state_next = sram_ctrl_pkg::burst_open;
                end
                else if (addrvalid && !datavalid)
                begin
                    // the sram latches the read address at this same edge
                    sram_addr  = sram_bus_pkg::pin_addr_t'(addr);
                    sram_adsp  = 1'b0;
                    sram_oe    = '0;
                    state_next = sram_ctrl_pkg::read_capture;
                end
            end

            sram_ctrl_pkg::burst_open:
            begin
                want_data = 1'b1;
                peek_next = sram_ctrl_pkg::peek_burst_open;
                if (!addr_ready)
                begin
                    state_next = sram_ctrl_pkg::burst_wait_data;
                end
            end

            sram_ctrl_pkg::burst_wait_data:
            begin
                want_addr     = 1'b1;
                want_data     = 1'b1;
                peek_next     = sram_ctrl_pkg::peek_burst_wait_data;
                sram_addr     = sram_bus_pkg::pin_addr_t'(waddr);
                sram_data_out = datain;
                if (addr_ready)
                begin
                    state_next = sram_ctrl_pkg::burst_close;  // a second address ends the burst
                end
                else if (data_ready)
                begin
                    sram_we    = '0;
                    sram_adsp  = 1'b0;
                    waddr_next = waddr + 1'b1;
                    state_next = sram_ctrl_pkg::burst_data_held;
                end
            end

            sram_ctrl_pkg::burst_data_held:
            begin
                want_addr = 1'b1;
                peek_next = sram_ctrl_pkg::peek_burst_data_held;
                if (!data_ready)
                begin
                    state_next = sram_ctrl_pkg::burst_wait_data;
                end
            end

            sram_ctrl_pkg::burst_close:
            begin
                peek_next = sram_ctrl_pkg::peek_burst_close;
                if (!addr_ready)
                begin
                    state_next = sram_ctrl_pkg::idle;
                end
            end

            sram_ctrl_pkg::read_capture:
            begin
                want_addr      = 1'b1;
                peek_next      = sram_ctrl_pkg::peek_read_capture;
                data_next      = sram_data_in;  // word at the address latched one edge ago
                datavalid_next = 1'b1;
                state_next     = sram_ctrl_pkg::idle;
            end

            default:
            begin
                state_next = sram_ctrl_pkg::idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/sync_sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sram_macros.svh"

// Pipelined synchronous SRAM. Address and output enables are registered
// on the strobe, the read word follows the registered address without a clock

module sync_sram_model (
    input  wire logic                     clk,
    input  wire sram_bus_pkg::pin_addr_t  sram_addr,
    input  wire sram_bus_pkg::data_word_t sram_data_out,
    input  wire sram_bus_pkg::we_mask_t   sram_we,
    input  wire sram_bus_pkg::oe_pair_t   sram_oe,
    input  wire logic                     sram_adsp,
    output sram_bus_pkg::data_word_t      sram_data_in
);

    localparam int depth = 1 << `SRAM_MODEL_DEPTH_LOG2;

    // only the low address bits select a word, higher bits alias
    sram_bus_pkg::data_word_t mem [depth] = '{default: '0};

    logic [`SRAM_MODEL_DEPTH_LOG2-1:0] lat_index = '0;
    sram_bus_pkg::oe_pair_t            lat_oe    = '1;  // outputs off until the first strobe

    always_ff @(posedge clk)
    begin
        if (!sram_adsp)
        begin
            lat_index <= sram_addr[`SRAM_MODEL_DEPTH_LOG2-1:0];
            lat_oe    <= sram_oe;
            if (sram_we == '0)
            begin
                mem[sram_addr[`SRAM_MODEL_DEPTH_LOG2-1:0]] <= sram_data_out;
            end
        end
    end

    // bus reads as zero while both output enables are inactive
    assign sram_data_in = (lat_oe != '1) ? mem[lat_index] : '0;

endmodule

`default_nettype wire

// ==== hw/sram_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_subsystem (
    input  wire logic                      clk,
    input  wire logic                      globalreset,
    output logic                           want_addr,
    input  wire logic                      addr_ready,
    input  wire sram_ctrl_pkg::word_addr_t addrin,
    output logic                           want_data,
    input  wire logic                      data_ready,
    input  wire sram_bus_pkg::data_word_t  datain,
    input  wire sram_ctrl_pkg::word_addr_t addr,
    input  wire logic                      addrvalid,
    output sram_bus_pkg::data_word_t       data,
    output logic                           datavalid,
    output sram_ctrl_pkg::state_peek_t     statepeek
);

    wire sram_bus_pkg::data_word_t sram_data_in;
    wire sram_bus_pkg::data_word_t sram_data_out;
    wire sram_bus_pkg::pin_addr_t  sram_addr;
    wire sram_bus_pkg::we_mask_t   sram_we;
    wire sram_bus_pkg::oe_pair_t   sram_oe;
    wire logic                     sram_adsp;

    sram_controller u_ctrl (
        .clk           (clk),
        .globalreset   (globalreset),
        .want_addr     (want_addr),
        .addr_ready    (addr_ready),
        .addrin        (addrin),
        .want_data     (want_data),
        .data_ready    (data_ready),
        .datain        (datain),
        .addr          (addr),
        .addrvalid     (addrvalid),
        .data          (data),
        .datavalid     (datavalid),
        .statepeek     (statepeek),
        .sram_data_in  (sram_data_in),
        .sram_data_out (sram_data_out),
        .sram_addr     (sram_addr),
        .sram_we       (sram_we),
        .sram_oe       (sram_oe),
        .sram_adsp     (sram_adsp)
    );

    // stands in for the external part on the board
    sync_sram_model u_sram (
        .clk           (clk),
        .sram_addr     (sram_addr),
        .sram_data_out (sram_data_out),
        .sram_we       (sram_we),
        .sram_oe       (sram_oe),
        .sram_adsp     (sram_adsp),
        .sram_data_in  (sram_data_in)
    );

endmodule

`default_nettype wire

// ==== tb/sram_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sram_macros.svh"

module sram_subsystem_tb;

    localparam int   clk_period_ns = 4;
    localparam int   reset_cycles  = 5;
    localparam int   max_ops       = 32;
    localparam int   wait_limit    = 16;  // cycles a handshake may take
    localparam int   ref_depth     = 1 << `SRAM_MODEL_DEPTH_LOG2;
    localparam logic op_read       = 1'b0;
    localparam logic op_write      = 1'b1;

    typedef struct packed {
        logic                      is_write;
        sram_ctrl_pkg::word_addr_t start;
        logic [7:0]                count;
        logic [3:0]                hold;  // cycles each strobe is held
    } op_t;

    logic                       clk;
    logic                       globalreset;
    logic                       addr_ready;
    sram_ctrl_pkg::word_addr_t  addrin;
    logic                       data_ready;
    sram_bus_pkg::data_word_t   datain;
    sram_ctrl_pkg::word_addr_t  addr;
    logic                       addrvalid;
    logic                       want_addr;
    logic                       want_data;
    sram_bus_pkg::data_word_t   data;
    logic                       datavalid;
    sram_ctrl_pkg::state_peek_t statepeek;

    op_t                        ops [max_ops];
    int                         num_ops = 0;
    sram_bus_pkg::data_word_t   ref_mem [ref_depth];  // what the sram should hold
    sram_bus_pkg::data_word_t   last_data;
    logic [31:0]                lcg_state = 32'd61279;
    int                         budget_cycles = 0;
    logic                       budget_ready = 1'b0;

    sram_subsystem DUT (
        .clk         (clk),
        .globalreset (globalreset),
        .want_addr   (want_addr),
        .addr_ready  (addr_ready),
        .addrin      (addrin),
        .want_data   (want_data),
        .data_ready  (data_ready),
        .datain      (datain),
        .addr        (addr),
        .addrvalid   (addrvalid),
        .data        (data),
        .datavalid   (datavalid),
        .statepeek   (statepeek)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clk_period_ns / 2) clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input sram_bus_pkg::data_word_t got,
                              input sram_bus_pkg::data_word_t exp, input string what);
        if (got !== exp)
        begin
            stop_with_failure($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_peek(input sram_ctrl_pkg::state_peek_t got,
                              input sram_ctrl_pkg::state_peek_t exp, input string what);
        if (got !== exp)
        begin
            stop_with_failure($sformatf("Fail at %0d ns: %s is %0d, expected %0d",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            stop_with_failure($sformatf("Fail at %0d ns: %s is %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_random_word(output sram_bus_pkg::data_word_t w);
        lcg_state = lcg_step(lcg_state);
        w[63:32]  = lcg_state;
        lcg_state = lcg_step(lcg_state);
        w[31:0]   = lcg_state;
    endtask

    // the model keeps only the low address bits, so the reference aliases the same way
    function automatic int ref_index(input sram_ctrl_pkg::word_addr_t a);
        return int'(a[`SRAM_MODEL_DEPTH_LOG2-1:0]);
    endfunction

    task automatic wait_for_want_data();
        int waited;
        waited = 0;
        while (want_data !== 1'b1)
        begin
            if (waited == wait_limit)
            begin
                stop_with_failure("want_data never rose, the controller did not ask for a word");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic add_op(input logic is_write, input sram_ctrl_pkg::word_addr_t start,
                          input int count, input int hold);
        if (num_ops == max_ops)
        begin
            stop_with_failure("the stimulus table has more rows than it can hold");
        end
        ops[num_ops].is_write = is_write;
        ops[num_ops].start    = start;
        ops[num_ops].count    = count[7:0];
        ops[num_ops].hold     = hold[3:0];
        num_ops++;
    endtask

    task automatic build_table();
        add_op(op_read,  18'h00010, 2, 1);  // never written, reads zero
        add_op(op_write, 18'h00010, 4, 1);
        add_op(op_read,  18'h00010, 5, 1);
        add_op(op_write, 18'h00100, 3, 3);  // held strobes write one word each
        add_op(op_read,  18'h00100, 4, 1);
        add_op(op_write, 18'h00012, 4, 2);  // overlaps the first burst
        add_op(op_read,  18'h0000f, 8, 1);
        add_op(op_write, 18'h3fffe, 4, 1);  // pointer wraps past the top
        add_op(op_read,  18'h3fffe, 4, 1);
        add_op(op_read,  18'h00000, 2, 1);
        add_op(op_write, 18'h00400, 2, 1);  // aliases word 0 in the model
        add_op(op_read,  18'h00000, 3, 1);
        add_op(op_read,  18'h2abcd, 2, 1);
        add_op(op_write, 18'h003ff, 2, 4);
        add_op(op_read,  18'h003ff, 2, 1);
    endtask

    task automatic run_burst(input sram_ctrl_pkg::word_addr_t start, input int count,
                             input int hold);
        sram_ctrl_pkg::word_addr_t ptr;
        sram_bus_pkg::data_word_t  word;
        int                        i;
        int                        k;
        ptr = start;
        check_bit(want_addr, 1'b1, "want_addr before a burst");
        check_bit(want_data, 1'b0, "want_data before a burst");
        addr_ready = 1'b1;
        addrin     = start;
        @(negedge clk);
        check_peek(statepeek, sram_ctrl_pkg::peek_idle, "statepeek entering burst_open");
        for (i = 1; i < hold; i++)
        begin
            @(negedge clk);
            check_peek(statepeek, sram_ctrl_pkg::peek_burst_open, "statepeek in burst_open");
        end
        check_bit(want_addr, 1'b0, "want_addr in burst_open");
        check_bit(want_data, 1'b1, "want_data in burst_open");
        addr_ready = 1'b0;
        addrin     = ~start;  // must not move the pointer
        @(negedge clk);
        check_peek(statepeek, sram_ctrl_pkg::peek_burst_open, "statepeek leaving burst_open");
        for (k = 0; k < count; k++)
        begin
            wait_for_want_data();
            check_bit(want_addr, 1'b1, "want_addr while waiting for data");
            next_random_word(word);
            ref_mem[ref_index(ptr)] = word;
            datain     = word;
            data_ready = 1'b1;
            @(negedge clk);
            check_bit(want_addr, 1'b1, "want_addr after a data strobe");
            check_bit(want_data, 1'b0, "want_data after a data strobe");
            check_peek(statepeek, sram_ctrl_pkg::peek_burst_wait_data,
                       "statepeek after a data strobe");
            for (i = 1; i < hold; i++)
            begin
                @(negedge clk);
                check_bit(want_data, 1'b0, "want_data while data_ready is held");
                check_peek(statepeek, sram_ctrl_pkg::peek_burst_data_held,
                           "statepeek while data_ready is held");
            end
            data_ready = 1'b0;
            datain     = ~word;
            ptr        = ptr + 1'b1;
            @(negedge clk);
            check_peek(statepeek, sram_ctrl_pkg::peek_burst_data_held,
                       "statepeek after data_ready drops");
        end
        wait_for_want_data();
        addr_ready = 1'b1;  // second address strobe closes the burst
        addrin     = ptr;
        @(negedge clk);
        check_bit(want_addr, 1'b0, "want_addr in burst_close");
        check_bit(want_data, 1'b0, "want_data in burst_close");
        check_peek(statepeek, sram_ctrl_pkg::peek_burst_wait_data, "statepeek entering close");
        for (i = 1; i < hold; i++)
        begin
            @(negedge clk);
            check_peek(statepeek, sram_ctrl_pkg::peek_burst_close, "statepeek in burst_close");
        end
        addr_ready = 1'b0;
        @(negedge clk);
        check_bit(want_addr, 1'b1, "want_addr after the burst");
        check_bit(want_data, 1'b0, "want_data after the burst");
        check_peek(statepeek, sram_ctrl_pkg::peek_burst_close, "statepeek after the burst");
    endtask

    task automatic run_reads(input sram_ctrl_pkg::word_addr_t start, input int count);
        sram_ctrl_pkg::word_addr_t a;
        sram_bus_pkg::data_word_t  exp;
        int                        k;
        for (k = 0; k < count; k++)
        begin
            a   = start + sram_ctrl_pkg::word_addr_t'(k);
            exp = ref_mem[ref_index(a)];
            check_bit(datavalid, 1'b0, "datavalid before a read");
            addr      = a;
            addrvalid = 1'b1;
            @(negedge clk);
            check_bit(datavalid, 1'b0, "datavalid one cycle into a read");
            check_word(data, last_data, "data one cycle into a read");
            check_peek(statepeek, sram_ctrl_pkg::peek_idle, "statepeek one cycle into a read");
            check_bit(want_addr, 1'b1, "want_addr in read_capture");
            check_bit(want_data, 1'b0, "want_data in read_capture");
            @(negedge clk);
            check_bit(datavalid, 1'b1, "datavalid two cycles into a read");
            check_word(data, exp, $sformatf("read data at address %h", a));
            check_peek(statepeek, sram_ctrl_pkg::peek_read_capture, "statepeek after capture");
            addr = a ^ 18'h002a5;  // a new address while addrvalid is held is ignored
            repeat (2)
            begin
                @(negedge clk);
                check_bit(datavalid, 1'b1, "datavalid while addrvalid is held");
                check_word(data, exp, "data while addrvalid is held");
            end
            addrvalid = 1'b0;
            @(negedge clk);
            check_bit(datavalid, 1'b0, "datavalid after addrvalid drops");
            check_word(data, exp, "data after addrvalid drops");
            last_data = exp;
        end
    endtask

    initial
    begin
        wait (budget_ready);
        #(budget_cycles * clk_period_ns);
        stop_with_failure($sformatf("timeout, the tests did not finish within %0d cycles",
                                    budget_cycles));
    end

    initial
    begin
        int i;
        globalreset = 1'b1;
        addr_ready  = 1'b0;
        addrin      = '0;
        data_ready  = 1'b0;
        datain      = '0;
        addr        = '0;
        addrvalid   = 1'b0;
        last_data   = '0;
        for (i = 0; i < ref_depth; i++)
        begin
            ref_mem[i] = '0;
        end
        build_table();
        budget_cycles = reset_cycles + 4;
        for (i = 0; i < num_ops; i++)
        begin
            if (ops[i].is_write)
            begin
                budget_cycles += 4 + 2 * int'(ops[i].hold)
                                 + int'(ops[i].count) * (int'(ops[i].hold) + 2);
            end
            else
            begin
                budget_cycles += 6 * int'(ops[i].count);
            end
        end
        budget_cycles += 100;  // margin for handshake waits
        budget_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        check_bit(want_addr, 1'b1, "want_addr in reset");
        check_bit(want_data, 1'b0, "want_data in reset");
        check_bit(datavalid, 1'b0, "datavalid in reset");
        check_word(data, '0, "data in reset");
        check_peek(statepeek, '0, "statepeek in reset");
        globalreset = 1'b0;
        @(negedge clk);
        check_peek(statepeek, sram_ctrl_pkg::peek_idle, "statepeek after reset");

        for (i = 0; i < num_ops; i++)
        begin
            if (ops[i].is_write)
            begin
                run_burst(ops[i].start, int'(ops[i].count), int'(ops[i].hold));
            end
            else
            begin
                run_reads(ops[i].start, int'(ops[i].count));
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/sram_bus_pkg.sv
hw/sram_ctrl_pkg.sv
hw/sram_controller.sv
hw/sync_sram_model.sv
hw/sram_subsystem.sv
tb/sram_subsystem_tb.sv
